//--- source/apb_sub_cfg.svh
`ifndef APB_SUB_CFG_SVH
`define APB_SUB_CFG_SVH

// ----------------------------------------------------------
// Slave windows
// ----------------------------------------------------------

// Window 0 is the ALUT and windows 1 to 4 the MAC blocks
`define APB_SUB_BASE0 32'h00A0_0000
`define APB_SUB_BASE1 32'h00A1_0000
`define APB_SUB_BASE2 32'h00A2_0000
`define APB_SUB_BASE3 32'h00A3_0000
`define APB_SUB_BASE4 32'h00A4_0000

// 64 KiB per window
`define APB_SUB_WIN_BITS 16
`define APB_SUB_NUM_SLV 5

// ----------------------------------------------------------
// Address lookup table
// ----------------------------------------------------------
`define ALUT_DEPTH 8
`define ALUT_KEY_OFS 7'h20
`define ALUT_RESULT_OFS 7'h24

`endif

//--- source/apb_sub_pkg.sv
package apb_sub_pkg;

   // Slave number with 0 the ALUT and 1 to 4 the MACs
   typedef logic [2:0] slave_idx_t;

   // AHB transfer types
   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_BUSY   = 2'b01,
      HTRANS_NONSEQ = 2'b10,
      HTRANS_SEQ    = 2'b11
   } htrans_e;

   // AHB responses in use
   typedef enum logic [1:0] {
      HRESP_OKAY  = 2'b00,
      HRESP_ERROR = 2'b01
   } hresp_e;

   // Captured address phase
   typedef struct packed {
      logic [31:0] addr;
      logic        write;
      slave_idx_t  slave;
   } ahb_req_t;

   // Response of the addressed APB slave
   typedef struct packed {
      logic [31:0] rdata;
      logic        ready;
   } apb_rsp_t;

   // One lookup table entry
   typedef struct packed {
      logic        valid;
      logic [1:0]  port;
      logic [15:0] tag;
   } alut_entry_t;

endpackage

//--- source/ahb_addr_decode.sv
`timescale 1ns/1ps
`include "apb_sub_cfg.svh"

module ahb_addr_decode import apb_sub_pkg::*; (
   input  logic        hclk,
   input  logic        reset,
   input  logic        hsel,
   input  logic [31:0] haddr,
   input  logic [1:0]  htrans,
   input  logic        hwrite,
   input  logic        hready_in,
   input  logic        hready,
   output ahb_req_t    req,
   output logic        req_valid,
   output logic        req_error
);

   localparam int NUM_SLV  = `APB_SUB_NUM_SLV;
   localparam int WIN_BITS = `APB_SUB_WIN_BITS;

   // Window bases in slave order
   localparam logic [31:0] WIN_BASE [NUM_SLV] = '{
      `APB_SUB_BASE0,
      `APB_SUB_BASE1,
      `APB_SUB_BASE2,
      `APB_SUB_BASE3,
      `APB_SUB_BASE4
   };

   logic       accept;
   logic       hit;
   slave_idx_t hit_idx;

   // ----------------------------------------------------------
   // Address phase acceptance
   // ----------------------------------------------------------

   // IDLE and BUSY fall through with no request
   assign accept = hsel && hready_in && hready &&
                   (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

   // Upper address bits against each window base
   always_comb begin
      hit     = 1'b0;
      hit_idx = '0;
      for (int i = 0; i < NUM_SLV; i++) begin
         if (haddr[31:WIN_BITS] == WIN_BASE[i][31:WIN_BITS]) begin
            hit     = 1'b1;
            hit_idx = slave_idx_t'(i);
         end
      end
   end

   // Pulses land in the data phase
   always_ff @(posedge hclk) begin
      if (reset) begin
         req_valid <= 1'b0;
         req_error <= 1'b0;
      end else begin
         req_valid <= accept && hit;
         req_error <= accept && !hit;
      end
   end

   // Held until the next accepted address
   always_ff @(posedge hclk) begin
      if (accept) begin
         req.addr  <= haddr;
         req.write <= hwrite;
         req.slave <= hit_idx;
      end
   end

   // One outcome per accepted address
   assert property (@(posedge hclk) disable iff (reset) !(req_valid && req_error))
      else $error("req_valid and req_error high together");

   // Bridge stalls hready so no request follows straight on
   assert property (@(posedge hclk) disable iff (reset) req_valid |=> !req_valid)
      else $error("back to back req_valid");

endmodule

//--- source/apb_sequencer.sv
`timescale 1ns/1ps
`include "apb_sub_cfg.svh"

module apb_sequencer import apb_sub_pkg::*; (
   input  logic                        hclk,
   input  logic                        reset,
   input  ahb_req_t                    req,
   input  logic                        req_valid,
   input  logic                        req_error,
   input  logic [31:0]                 hwdata,
   input  apb_rsp_t                    rsp,
   output logic [31:0]                 paddr,
   output logic                        pwrite,
   output logic [31:0]                 pwdata,
   output logic                        penable,
   output logic [`APB_SUB_NUM_SLV-1:0] psel,
   output logic                        hready,
   output logic [1:0]                  hresp
);

   localparam int NUM_SLV = `APB_SUB_NUM_SLV;

   typedef enum logic [2:0] {
      S_IDLE,
      S_DATA,
      S_SETUP,
      S_ACCESS,
      S_ERR1,
      S_ERR2
   } state_e;

   state_e      state_q;
   state_e      state;
   state_e      state_nxt;
   logic [31:0] pwdata_q;

   // ----------------------------------------------------------
   // State machine
   // ----------------------------------------------------------

   // Decode pulses arrive in the data phase itself
   // so DATA and ERR1 are taken straight from them
   always_comb begin
      state = state_q;
      if (state_q == S_IDLE && req_valid) begin
         state = S_DATA;
      end else if (state_q == S_IDLE && req_error) begin
         state = S_ERR1;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE:   state_nxt = S_IDLE;
         S_DATA:   state_nxt = S_SETUP;
         S_SETUP:  state_nxt = S_ACCESS;
         // Access phase stretched by pready low
         S_ACCESS: state_nxt = rsp.ready ? S_IDLE : S_ACCESS;
         S_ERR1:   state_nxt = S_ERR2;
         S_ERR2:   state_nxt = S_IDLE;
         default:  state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge hclk) begin
      if (reset) begin
         state_q <= S_IDLE;
      end else begin
         state_q <= state_nxt;
      end
   end

   // Write data valid during the data phase
   always_ff @(posedge hclk) begin
      if (state == S_DATA) begin
         pwdata_q <= hwdata;
      end
   end

   // ----------------------------------------------------------
   // AHB and APB outputs
   // ----------------------------------------------------------
   assign hready  = (state == S_IDLE) || (state == S_ERR2);
   assign hresp   = (state == S_ERR1 || state == S_ERR2) ? HRESP_ERROR : HRESP_OKAY;
   assign penable = (state == S_ACCESS);
   assign psel    = (state == S_SETUP || state == S_ACCESS) ?
                    (NUM_SLV'(1) << req.slave) : '0;
   assign paddr   = req.addr;
   assign pwrite  = req.write;
   assign pwdata  = pwdata_q;

   // Only one slave addressed
   assert property (@(posedge hclk) disable iff (reset) $onehot0(psel))
      else $error("psel not one-hot");

   // Setup cycle before every access
   assert property (@(posedge hclk) disable iff (reset)
      $rose(penable) |-> $past((|psel) && !penable))
      else $error("penable without setup cycle");

   // Address register in the decoder must not move mid-access
   assert property (@(posedge hclk) disable iff (reset) penable |-> $stable(paddr))
      else $error("paddr changed during access");

endmodule

//--- source/apb_read_mux.sv
`timescale 1ns/1ps
`include "apb_sub_cfg.svh"

module apb_read_mux import apb_sub_pkg::*; (
   input  logic                                hclk,
   input  logic                                reset,
   input  logic [`APB_SUB_NUM_SLV-1:0]         psel,
   input  logic                                penable,
   input  logic [31:0]                         prdata_alut,
   input  logic [`APB_SUB_NUM_SLV-2:0][31:0]   prdata_mac,
   input  logic [`APB_SUB_NUM_SLV-2:0]         pready_mac,
   output apb_rsp_t                            rsp,
   output logic [31:0]                         hrdata
);

   localparam int NUM_MAC = `APB_SUB_NUM_SLV - 1;

   // ----------------------------------------------------------
   // Slave response select
   // ----------------------------------------------------------

   // ALUT never waits and an idle bus reads as ready
   always_comb begin
      rsp.rdata = '0;
      rsp.ready = 1'b1;
      if (psel[0]) begin
         rsp.rdata = prdata_alut;
         rsp.ready = 1'b1;
      end
      for (int i = 0; i < NUM_MAC; i++) begin
         if (psel[i+1]) begin
            rsp.rdata = prdata_mac[i];
            rsp.ready = pready_mac[i];
         end
      end
   end

   // Read word captured on the last access edge
   // and held for the cycle hready returns
   always_ff @(posedge hclk) begin
      if (reset) begin
         hrdata <= '0;
      end else if (penable && rsp.ready) begin
         hrdata <= rsp.rdata;
      end
   end

endmodule

//--- source/alut_regs.sv
`timescale 1ns/1ps
`include "apb_sub_cfg.svh"

module alut_regs import apb_sub_pkg::*; (
   input  logic        hclk,
   input  logic        reset,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata
);

   localparam int DEPTH    = `ALUT_DEPTH;
   localparam int IDX_BITS = $clog2(DEPTH);

   alut_entry_t         entries_q [DEPTH];
   logic [15:0]         key_q;
   logic                wr_en;
   logic                entry_sel;
   logic [IDX_BITS-1:0] idx;
   logic                hit;
   logic [1:0]          hit_port;

   // Bus word layout of an entry
   function automatic logic [31:0] entry_to_word(alut_entry_t e);
      return {e.valid, 13'b0, e.port, e.tag};
   endfunction

   function automatic alut_entry_t word_to_entry(logic [31:0] w);
      alut_entry_t e;
      e.valid = w[31];
      e.port  = w[17:16];
      e.tag   = w[15:0];
      return e;
   endfunction

   // ----------------------------------------------------------
   // Register writes
   // ----------------------------------------------------------
   assign wr_en     = psel && penable && pwrite;
   // Entries at offsets 0 to 0x1C
   assign entry_sel = (paddr[6:2+IDX_BITS] == '0);
   assign idx       = paddr[2 +: IDX_BITS];

   always_ff @(posedge hclk) begin
      if (reset) begin
         for (int i = 0; i < DEPTH; i++) begin
            entries_q[i] <= '0;
         end
         key_q <= '0;
      end else if (wr_en) begin
         if (entry_sel) begin
            entries_q[idx] <= word_to_entry(pwdata);
         end else if (paddr == `ALUT_KEY_OFS) begin
            key_q <= pwdata[15:0];
         end
      end
   end

   // ----------------------------------------------------------
   // Lookup and read back
   // ----------------------------------------------------------

   // Walk downwards so the lowest matching index wins
   always_comb begin
      hit      = 1'b0;
      hit_port = '0;
      for (int i = DEPTH - 1; i >= 0; i--) begin
         if (entries_q[i].valid && entries_q[i].tag == key_q) begin
            hit      = 1'b1;
            hit_port = entries_q[i].port;
         end
      end
   end

   always_comb begin
      prdata = '0;
      if (entry_sel) begin
         prdata = entry_to_word(entries_q[idx]);
      end else if (paddr == `ALUT_KEY_OFS) begin
         prdata = {16'b0, key_q};
      end else if (paddr == `ALUT_RESULT_OFS) begin
         prdata = {hit, 29'b0, hit_port};
      end
   end

   // Byte offsets from the bridge are word sized only
   assert property (@(posedge hclk) disable iff (reset) psel |-> (paddr[1:0] == 2'b00))
      else $error("unaligned ALUT access");

endmodule

//--- source/apb_subsystem.sv
`timescale 1ns/1ps
`include "apb_sub_cfg.svh"

module apb_subsystem import apb_sub_pkg::*; (
   // AHB slave port
   input  logic        hclk,
   input  logic        reset,
   input  logic        hsel,
   input  logic [31:0] haddr,
   input  logic [1:0]  htrans,
   input  logic        hwrite,
   input  logic [31:0] hwdata,
   input  logic        hready_in,
   output logic [31:0] hrdata,
   output logic        hready,
   output logic [1:0]  hresp,
   // APB bus shared by the MACs
   output logic [31:0] paddr,
   output logic        pwrite,
   output logic        penable,
   output logic [31:0] pwdata,
   output logic        psel_mac0,
   output logic        psel_mac1,
   output logic        psel_mac2,
   output logic        psel_mac3,
   input  logic [31:0] prdata_mac0,
   input  logic [31:0] prdata_mac1,
   input  logic [31:0] prdata_mac2,
   input  logic [31:0] prdata_mac3,
   input  logic        pready_mac0,
   input  logic        pready_mac1,
   input  logic        pready_mac2,
   input  logic        pready_mac3
);

   localparam int NUM_SLV = `APB_SUB_NUM_SLV;

   ahb_req_t           req;
   logic               req_valid;
   logic               req_error;
   apb_rsp_t           rsp;
   logic [NUM_SLV-1:0] psel;
   logic               psel_alut;
   logic [31:0]        prdata_alut;

   // ----------------------------------------------------------
   // Select split
   // ----------------------------------------------------------
   assign psel_alut = psel[0];
   assign psel_mac0 = psel[1];
   assign psel_mac1 = psel[2];
   assign psel_mac2 = psel[3];
   assign psel_mac3 = psel[4];

   // ----------------------------------------------------------
   // Bridge
   // ----------------------------------------------------------
   ahb_addr_decode u_decode (
      .hclk      (hclk),
      .reset     (reset),
      .hsel      (hsel),
      .haddr     (haddr),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hready_in (hready_in),
      .hready    (hready),
      .req       (req),
      .req_valid (req_valid),
      .req_error (req_error)
   );

   apb_sequencer u_sequencer (
      .hclk      (hclk),
      .reset     (reset),
      .req       (req),
      .req_valid (req_valid),
      .req_error (req_error),
      .hwdata    (hwdata),
      .rsp       (rsp),
      .paddr     (paddr),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .penable   (penable),
      .psel      (psel),
      .hready    (hready),
      .hresp     (hresp)
   );

   apb_read_mux u_read_mux (
      .hclk        (hclk),
      .reset       (reset),
      .psel        (psel),
      .penable     (penable),
      .prdata_alut (prdata_alut),
      .prdata_mac  ({prdata_mac3, prdata_mac2, prdata_mac1, prdata_mac0}),
      .pready_mac  ({pready_mac3, pready_mac2, pready_mac1, pready_mac0}),
      .rsp         (rsp),
      .hrdata      (hrdata)
   );

   // Slave 0 sees the low address bits only
   alut_regs u_alut (
      .hclk    (hclk),
      .reset   (reset),
      .psel    (psel_alut),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr[6:0]),
      .pwdata  (pwdata),
      .prdata  (prdata_alut)
   );

endmodule

//--- bench/tb_apb_subsystem.sv
`timescale 1ns/1ps
`include "apb_sub_cfg.svh"

module tb_apb_subsystem import apb_sub_pkg::*; ();

   localparam int RESET_CYCLES = 10;
   // Transfers in all test sections with the idle section counted as one
   localparam int NUM_XFERS    = 16 + 24 + 32 + 3 + 1;
   localparam int CYCLE_LIMIT  = NUM_XFERS * 12 + RESET_CYCLES;
   localparam logic [31:0] MAC_BASE [4] = '{
      `APB_SUB_BASE1,
      `APB_SUB_BASE2,
      `APB_SUB_BASE3,
      `APB_SUB_BASE4
   };
   localparam logic [31:0] BAD_ADDR = 32'h00B0_0040;

   logic        hclk = 1'b0;
   logic        reset;
   logic        hsel;
   logic [31:0] haddr;
   logic [1:0]  htrans;
   logic        hwrite;
   logic [31:0] hwdata;
   logic        hready_in;
   logic [31:0] hrdata;
   logic        hready;
   logic [1:0]  hresp;
   logic [31:0] paddr;
   logic        pwrite;
   logic        penable;
   logic [31:0] pwdata;
   logic        psel_mac0;
   logic        psel_mac1;
   logic        psel_mac2;
   logic        psel_mac3;
   logic [3:0]  psel_v;
   logic [3:0]  pready_v = '0;
   logic [31:0] prdata_v [4] = '{default: '0};

   // MAC model state
   logic [31:0] mac_mem [4][16];
   logic [1:0]  wait_left [4];
   logic [31:0] last_wr_addr [4];
   logic [31:0] last_wr_data [4];
   logic        last_pwrite [4];
   logic [31:0] wait_lfsr;
   logic [31:0] stim_lfsr;

   // Expected contents
   logic [31:0] alut_shadow [8];
   logic [31:0] mac_shadow [4][16];

   // Pending checks and counts
   string       name_q [$];
   logic [31:0] exp_q [$];
   logic [31:0] got_q [$];
   int          value_errs = 0;
   int          protocol_errs = 0;
   int          timeouts = 0;
   int          cycle_cnt = 0;
   logic        no_psel = 1'b0;
   logic [3:0]  prev_psel_v = '0;
   logic        prev_penable = 1'b0;

   assign psel_v = {psel_mac3, psel_mac2, psel_mac1, psel_mac0};

   always #4 hclk = ~hclk;

   apb_subsystem DUT (
      .hclk        (hclk),
      .reset       (reset),
      .hsel        (hsel),
      .haddr       (haddr),
      .htrans      (htrans),
      .hwrite      (hwrite),
      .hwdata      (hwdata),
      .hready_in   (hready_in),
      .hrdata      (hrdata),
      .hready      (hready),
      .hresp       (hresp),
      .paddr       (paddr),
      .pwrite      (pwrite),
      .penable     (penable),
      .pwdata      (pwdata),
      .psel_mac0   (psel_mac0),
      .psel_mac1   (psel_mac1),
      .psel_mac2   (psel_mac2),
      .psel_mac3   (psel_mac3),
      .prdata_mac0 (prdata_v[0]),
      .prdata_mac1 (prdata_v[1]),
      .prdata_mac2 (prdata_v[2]),
      .prdata_mac3 (prdata_v[3]),
      .pready_mac0 (pready_v[0]),
      .pready_mac1 (pready_v[1]),
      .pready_mac2 (pready_v[2]),
      .pready_mac3 (pready_v[3])
   );

   // ----------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------

   // Taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         stim_lfsr = lfsr_step(stim_lfsr);
         v = {v[30:0], stim_lfsr[0]};
      end
   endtask

   // Lowest valid entry with a matching tag
   function automatic logic [31:0] lookup_ref(input logic [15:0] key);
      for (int i = 0; i < 8; i++) begin
         if (alut_shadow[i][31] && alut_shadow[i][15:0] == key) begin
            return {1'b1, 29'b0, alut_shadow[i][17:16]};
         end
      end
      return '0;
   endfunction

   task automatic queue_check(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      name_q.push_back(name);
      exp_q.push_back(exp);
      got_q.push_back(got);
   endtask

   // Single transfer that returns once hready is back high
   task automatic ahb_transfer(input logic [31:0] addr, input logic write,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic [1:0] resp, output logic [1:0] resp_lo,
                               output int lo_cycles);
      @(posedge hclk);
      hsel   <= 1'b1;
      haddr  <= addr;
      hwrite <= write;
      htrans <= HTRANS_NONSEQ;
      @(posedge hclk);
      // Data phase
      htrans <= HTRANS_IDLE;
      hwdata <= wdata;
      lo_cycles = 0;
      resp_lo   = HRESP_OKAY;
      @(negedge hclk);
      while (!hready) begin
         lo_cycles++;
         resp_lo = hresp;
         @(negedge hclk);
      end
      resp  = hresp;
      rdata = hrdata;
   endtask

   task automatic finish_run();
      $display("value errors %0d, protocol errors %0d, timeouts %0d",
               value_errs, protocol_errs, timeouts);
      if (value_errs + protocol_errs + timeouts == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   // ----------------------------------------------------------
   // MAC register block models
   // ----------------------------------------------------------
   always @(posedge hclk) begin : mac_models
      logic [1:0] w;
      if (reset) begin
         wait_lfsr = 32'hdada;
         for (int m = 0; m < 4; m++) begin
            pready_v[m]     <= 1'b0;
            wait_left[m]    <= '0;
            prdata_v[m]     <= '0;
            last_wr_addr[m] <= '0;
            last_wr_data[m] <= '0;
            last_pwrite[m]  <= 1'b0;
            for (int a = 0; a < 16; a++) begin
               mac_mem[m][a] <= '0;
            end
         end
      end else begin
         for (int m = 0; m < 4; m++) begin
            if (psel_v[m] && !penable) begin
               // Setup edge picks 0 to 3 waits
               wait_lfsr = lfsr_step(wait_lfsr);
               w[0] = wait_lfsr[0];
               wait_lfsr = lfsr_step(wait_lfsr);
               w[1] = wait_lfsr[0];
               wait_left[m] <= w;
               pready_v[m]  <= (w == 2'd0);
               prdata_v[m]  <= mac_mem[m][paddr[5:2]];
            end else if (psel_v[m] && penable && !pready_v[m]) begin
               wait_left[m] <= wait_left[m] - 2'd1;
               pready_v[m]  <= (wait_left[m] == 2'd1);
            end else if (psel_v[m] && penable && pready_v[m]) begin
               pready_v[m]    <= 1'b0;
               last_pwrite[m] <= pwrite;
               if (pwrite) begin
                  mac_mem[m][paddr[5:2]] <= pwdata;
                  last_wr_addr[m]        <= paddr;
                  last_wr_data[m]        <= pwdata;
               end
            end
         end
      end
   end

   // ----------------------------------------------------------
   // Checking processes
   // ----------------------------------------------------------
   always @(negedge hclk) begin : compare
      string       n;
      logic [31:0] e;
      logic [31:0] g;
      while (name_q.size() != 0) begin
         n = name_q.pop_front();
         e = exp_q.pop_front();
         g = got_q.pop_front();
         assert (g === e) else begin
            $display("FAIL %s expected %h got %h", n, e, g);
            value_errs++;
         end
      end
   end

   // APB protocol seen at the MAC ports
   always @(negedge hclk) begin : monitor
      if (!reset) begin
         assert ($onehot0(psel_v)) else begin
            $display("More than one MAC select is high at once");
            protocol_errs++;
         end
         if (penable && !prev_penable && (|psel_v)) begin
            assert (prev_psel_v == psel_v) else begin
               $display("penable rose without a cycle of psel alone before it");
               protocol_errs++;
            end
         end
         if (no_psel) begin
            assert (!(|psel_v) && !penable) else begin
               $display("A MAC select or penable rose when no APB transfer was due");
               protocol_errs++;
            end
         end
      end
      prev_psel_v  = psel_v;
      prev_penable = penable;
   end

   always @(posedge hclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout with the run still going after %0d cycles", cycle_cnt);
         timeouts = timeouts + 1;
         finish_run();
      end
   end

   // ----------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------
   initial begin : stimulus
      logic [31:0] r;
      logic [31:0] word;
      logic [31:0] rd;
      logic [31:0] addr;
      logic [15:0] key;
      logic [1:0]  resp;
      logic [1:0]  resp_lo;
      int          lo;
      logic [3:0]  idx [4];

      stim_lfsr = 32'hdada;
      reset     <= 1'b1;
      hsel      <= 1'b0;
      haddr     <= '0;
      htrans    <= HTRANS_IDLE;
      hwrite    <= 1'b0;
      hwdata    <= '0;
      hready_in <= 1'b1;
      for (int m = 0; m < 4; m++) begin
         for (int a = 0; a < 16; a++) begin
            mac_shadow[m][a] = '0;
         end
      end
      repeat (RESET_CYCLES) @(posedge hclk);
      reset <= 1'b0;

      // Idle bus after reset
      @(negedge hclk);
      queue_check("hready", 32'd1, 32'(hready));
      queue_check("hresp", 32'(HRESP_OKAY), 32'(hresp));
      queue_check("psel_mac", 32'd0, 32'(psel_v));
      queue_check("penable", 32'd0, 32'(penable));

      // ALUT entries with random fill in unused bits
      for (int i = 0; i < 8; i++) begin
         take_bits(32, word);
         word[15:0] = {13'h0200, word[2:0]};
         // Entry 6 repeats the tag of entry 2
         if (i == 6) begin
            word[15:0] = alut_shadow[2][15:0];
         end
         word[31] = (i != 5);
         alut_shadow[i] = word & 32'h8003_FFFF;
         ahb_transfer(`APB_SUB_BASE0 + 32'(i * 4), 1'b1, word, rd, resp, resp_lo, lo);
         queue_check("hresp", 32'(HRESP_OKAY), 32'(resp));
      end
      for (int i = 0; i < 8; i++) begin
         ahb_transfer(`APB_SUB_BASE0 + 32'(i * 4), 1'b0, '0, rd, resp, resp_lo, lo);
         queue_check("hrdata", alut_shadow[i], rd);
         queue_check("hready low cycles", 32'd3, 32'(lo));
      end

      // Lookups with hits, misses and a duplicate tag
      for (int k = 0; k < 12; k++) begin
         take_bits(16, r);
         if (k == 0) begin
            key = alut_shadow[6][15:0];
         end else if (k % 4 == 3) begin
            key = r[15:0] | 16'h4000;
         end else begin
            key = {13'h0200, r[2:0]};
         end
         ahb_transfer(`APB_SUB_BASE0 + 32'(`ALUT_KEY_OFS), 1'b1, {16'b0, key},
                      rd, resp, resp_lo, lo);
         ahb_transfer(`APB_SUB_BASE0 + 32'(`ALUT_RESULT_OFS), 1'b0, '0,
                      rd, resp, resp_lo, lo);
         queue_check("alut result", lookup_ref(key), rd);
      end

      // MAC windows with random waits
      for (int m = 0; m < 4; m++) begin
         for (int j = 0; j < 4; j++) begin
            take_bits(4, r);
            idx[j] = r[3:0];
            take_bits(32, word);
            addr = MAC_BASE[m] + {26'b0, idx[j], 2'b00};
            ahb_transfer(addr, 1'b1, word, rd, resp, resp_lo, lo);
            mac_shadow[m][idx[j]] = word;
            queue_check("hresp", 32'(HRESP_OKAY), 32'(resp));
            queue_check("pwrite at MAC", 32'd1, 32'(last_pwrite[m]));
            queue_check("paddr at MAC", addr, last_wr_addr[m]);
            queue_check("pwdata at MAC", word, last_wr_data[m]);
         end
         for (int j = 0; j < 4; j++) begin
            addr = MAC_BASE[m] + {26'b0, idx[j], 2'b00};
            ahb_transfer(addr, 1'b0, '0, rd, resp, resp_lo, lo);
            queue_check("pwrite at MAC", 32'd0, 32'(last_pwrite[m]));
            queue_check("hrdata", mac_shadow[m][idx[j]], rd);
         end
      end

      // Unmapped addresses
      no_psel = 1'b1;
      ahb_transfer(BAD_ADDR, 1'b1, 32'h1234_5678, rd, resp, resp_lo, lo);
      queue_check("hready low cycles", 32'd1, 32'(lo));
      queue_check("hresp with hready low", 32'(HRESP_ERROR), 32'(resp_lo));
      queue_check("hresp with hready high", 32'(HRESP_ERROR), 32'(resp));
      ahb_transfer(32'h0000_0100, 1'b0, '0, rd, resp, resp_lo, lo);
      queue_check("hready low cycles", 32'd1, 32'(lo));
      queue_check("hresp with hready low", 32'(HRESP_ERROR), 32'(resp_lo));
      queue_check("hresp with hready high", 32'(HRESP_ERROR), 32'(resp));
      no_psel = 1'b0;
      // Bridge still usable
      ahb_transfer(MAC_BASE[3] + {26'b0, idx[0], 2'b00}, 1'b0, '0, rd, resp, resp_lo, lo);
      queue_check("hrdata", mac_shadow[3][idx[0]], rd);
      queue_check("hresp", 32'(HRESP_OKAY), 32'(resp));

      // IDLE with hsel high
      no_psel = 1'b1;
      @(posedge hclk);
      hsel   <= 1'b1;
      haddr  <= MAC_BASE[0];
      hwrite <= 1'b1;
      htrans <= HTRANS_IDLE;
      repeat (4) begin
         @(negedge hclk);
         queue_check("hready", 32'd1, 32'(hready));
         queue_check("hresp", 32'(HRESP_OKAY), 32'(hresp));
      end
      no_psel = 1'b0;

      // Let the compare process drain
      repeat (2) @(negedge hclk);
      finish_run();
   end

endmodule

//--- vlog.f
+incdir+source
source/apb_sub_pkg.sv
source/ahb_addr_decode.sv
source/apb_sequencer.sv
source/apb_read_mux.sv
source/alut_regs.sv
source/apb_subsystem.sv
bench/tb_apb_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_apb_subsystem \
   -o tb_apb_subsystem
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_apb_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
   exit 1
fi
exit 0
